// File: list.f
logic/sys_pkg.sv
logic/video_timing_if.sv
logic/host_cfg_regs.sv
logic/video_window_calc.sv
logic/audio_channel_mix.sv
logic/sys_core_top.sv
tb/sys_core_asserts.sv
tb/sys_core_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module sys_core_tb -f list.f -o sys_core_sim

status=0
./obj_dir/sys_core_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	exit 1
fi

# A run stopped by a bound assertion never reaches the closing line
if [ "$status" -ne 0 ] || ! grep -q "Simulation finished: PASS" sim.log; then
	exit 1
fi

// File: tb/sys_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module sys_core_tb;

	localparam int IO_SYNC_STAGES = 2;
	localparam int WAIT_LIMIT     = 64;
	localparam int TIMING_SET [8] = '{1280, 110, 40, 220, 720, 5, 5, 20};

	logic                clk_sys;
	logic                resetd;
	logic                io_clk;
	logic                io_uio;
	sys_pkg::host_word_t io_din;
	logic                io_ack;
	sys_pkg::host_word_t cfg;
	logic                led_user;
	logic [1:0]          led_power;
	logic [1:0]          led_disk;
	sys_pkg::led_t       led;
	sys_pkg::aspect_t    arx;
	sys_pkg::aspect_t    ary;
	sys_pkg::dim_t       hmin;
	sys_pkg::dim_t       hmax;
	sys_pkg::dim_t       vmin;
	sys_pkg::dim_t       vmax;
	sys_pkg::sample_t    core_l;
	sys_pkg::sample_t    core_r;
	sys_pkg::sample_t    linux_l;
	sys_pkg::sample_t    linux_r;
	logic                audio_signed;
	sys_pkg::mix_t       audio_mix;
	sys_pkg::sample_t    audio_l;
	sys_pkg::sample_t    audio_r;

	// Register contents the DUT should hold after the frames sent so far
	sys_pkg::dim_t width_m;
	sys_pkg::dim_t height_m;
	sys_pkg::dim_t vset_m;
	int            att_m;

	string               test_name;
	int                  checks;
	int                  errors;
	int                  test_errors;
	int                  tests_run;
	int                  tests_failed;
	int                  rises_before;
	int                  ack_rises = 0;
	logic                ack_prev = 1'b0;
	sys_pkg::host_word_t tx_words [$];

	sys_core_top #(
		.IO_SYNC_STAGES(IO_SYNC_STAGES)
	) sys_core_top_i (
		.i_clk_sys      (clk_sys),
		.i_resetd       (resetd),
		.i_io_clk       (io_clk),
		.i_io_uio       (io_uio),
		.i_io_din       (io_din),
		.o_io_ack       (io_ack),
		.o_cfg          (cfg),
		.i_led_user     (led_user),
		.i_led_power    (led_power),
		.i_led_disk     (led_disk),
		.o_led          (led),
		.i_arx          (arx),
		.i_ary          (ary),
		.o_hmin         (hmin),
		.o_hmax         (hmax),
		.o_vmin         (vmin),
		.o_vmax         (vmax),
		.i_core_l       (core_l),
		.i_core_r       (core_r),
		.i_linux_l      (linux_l),
		.i_linux_r      (linux_r),
		.i_audio_signed (audio_signed),
		.i_audio_mix    (audio_mix),
		.o_audio_l      (audio_l),
		.o_audio_r      (audio_r)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// Count ack pulses independently of the host driver
	always @(posedge clk_sys) begin
		ack_prev <= io_ack;
		if (io_ack && !ack_prev)
			ack_rises <= ack_rises + 1;
	end

	//////////////////////////////////////////////////
	// Host driver
	//////////////////////////////////////////////////

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timeout in %s: %s", test_name, what);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while ((io_ack !== level) && (n < WAIT_LIMIT)) begin
			wait_cycles(1);
			n++;
		end
		if (io_ack !== level)
			abort_on_timeout($sformatf("host ack never went to %0b", level));
	endtask

	task automatic send_word(input sys_pkg::host_word_t w);
		io_din = w;
		io_clk = 1'b1;
		wait_ack(1'b1);
		io_clk = 1'b0;
		wait_ack(1'b0);
	endtask

	// Command word first, then the queued data words
	task automatic send_frame(input sys_pkg::cmd_t cmd);
		io_uio = 1'b1;
		send_word({8'h00, cmd});
		foreach (tx_words[i])
			send_word(tx_words[i]);
		io_uio = 1'b0;
		tx_words.delete();
		wait_cycles(IO_SYNC_STAGES + 4);
	endtask

	//////////////////////////////////////////////////
	// Checking and reference rules
	//////////////////////////////////////////////////

	task automatic check_value(input string what, input int expected, input int actual);
		checks++;
		assert (expected == actual)
		else begin
			$display("** Error %s %s: expected 0x%0h, actual 0x%0h",
				test_name, what, expected, actual);
			test_errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests_run++;
		errors += test_errors;
		if (test_errors != 0)
			tests_failed++;
		$display("%s: %s (%0d errors)", test_name, (test_errors == 0) ? "ok" : "bad",
			test_errors);
	endtask

	task automatic check_window();
		int base;
		int cand_w;
		int cand_h;
		int vid_w;
		int vid_h;
		base = (vset_m != 0) ? int'(vset_m) : int'(height_m);
		cand_w = base * int'(arx) / int'(ary);
		cand_h = int'(width_m) * int'(ary) / int'(arx);
		vid_w = ((vset_m == 0) && (cand_w > int'(width_m))) ? int'(width_m) : cand_w;
		if (vset_m != 0)
			vid_h = vset_m;
		else
			vid_h = (cand_h > int'(height_m)) ? int'(height_m) : cand_h;
		check_value("hmin", (int'(width_m) - vid_w) / 2, hmin);
		check_value("hmax", (int'(width_m) - vid_w) / 2 + vid_w - 1, hmax);
		check_value("vmin", (int'(height_m) - vid_h) / 2, vmin);
		check_value("vmax", (int'(height_m) - vid_h) / 2 + vid_h - 1, vmax);
	endtask

	function automatic sys_pkg::led_t led_expected(input sys_pkg::led_t mask,
		input sys_pkg::led_t state, input int combo);
		sys_pkg::led_t leds;
		leds = '0;
		leds[0] = combo[0];
		leds[2] = combo[3];
		leds[4] = combo[2] ? combo[1] : 1'b1;
		for (int b = 0; b < 8; b++) begin
			if (mask[b])
				leds[b] = state[b];
		end
		return leds;
	endfunction

	// Walks user, power and disk through all 32 settings
	task automatic check_leds(input sys_pkg::led_t mask, input sys_pkg::led_t state);
		for (int i = 0; i < 32; i++) begin
			led_user = i[0];
			led_power = i[2:1];
			led_disk = i[4:3];
			wait_cycles(1);
			check_value($sformatf("led setting %0d", i), led_expected(mask, state, i), led);
		end
	endtask

	function automatic int channel_sum(input sys_pkg::sample_t core,
		input sys_pkg::sample_t lin, input logic is_signed);
		int c;
		if (is_signed)
			c = $signed(core);
		else
			c = int'(core) / 2;
		return c + $signed(lin);
	endfunction

	function automatic sys_pkg::sample_t audio_expected(input int sum_self,
		input int sum_other, input sys_pkg::mix_t mix, input int att);
		int v;
		v = (mix == 2'd3) ? (sum_self >>> 1) + (sum_other >>> 1) : sum_self;
		v = (att >= 16) ? 0 : (v >>> att);
		if (v > 32767)
			v = 32767;
		else if (v < -32768)
			v = -32768;
		return sys_pkg::sample_t'(v);
	endfunction

	task automatic check_audio(input string what);
		int sum_l;
		int sum_r;
		sum_l = channel_sum(core_l, linux_l, audio_signed);
		sum_r = channel_sum(core_r, linux_r, audio_signed);
		wait_cycles(16);
		check_value({what, " left"}, audio_expected(sum_l, sum_r, audio_mix, att_m), audio_l);
		check_value({what, " right"}, audio_expected(sum_r, sum_l, audio_mix, att_m), audio_r);
	endtask

	task automatic pick_samples();
		core_l = sys_pkg::sample_t'($urandom());
		core_r = sys_pkg::sample_t'($urandom());
		linux_l = sys_pkg::sample_t'($urandom());
		linux_r = sys_pkg::sample_t'($urandom());
	endtask

	//////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////

	initial begin
		void'($urandom(29));
		resetd = 1'b1;
		io_clk = 1'b0;
		io_uio = 1'b0;
		io_din = '0;
		led_user = 1'b0;
		led_power = 2'b00;
		led_disk = 2'b00;
		arx = 8'd16;
		ary = 8'd9;
		core_l = '0;
		core_r = '0;
		linux_l = '0;
		linux_r = '0;
		audio_signed = 1'b0;
		audio_mix = 2'd0;
		width_m = sys_pkg::DEF_WIDTH;
		height_m = sys_pkg::DEF_HEIGHT;
		vset_m = '0;
		att_m = 0;
		checks = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		wait_cycles(3);
		resetd = 1'b0;

		start_test("reset_defaults");
		wait_cycles(16);
		check_window();
		check_value("cfg", 0, cfg);
		end_test();

		start_test("cfg_and_ack");
		rises_before = ack_rises;
		tx_words.push_back(16'hC35A);
		send_frame(sys_pkg::CMD_CFG);
		check_value("cfg", 16'hC35A, cfg);
		check_value("ack pulses", 2, ack_rises - rises_before);
		end_test();

		start_test("timing_and_vset");
		arx = 8'd4;
		ary = 8'd3;
		foreach (TIMING_SET[i])
			tx_words.push_back(sys_pkg::host_word_t'(TIMING_SET[i]));
		send_frame(sys_pkg::CMD_TIMING);
		width_m = 12'd1280;
		height_m = 12'd720;
		wait_cycles(16);
		check_window();
		tx_words.push_back(16'd600);
		send_frame(sys_pkg::CMD_VSET);
		vset_m = 12'd600;
		wait_cycles(16);
		check_window();
		end_test();

		start_test("led_override");
		check_leds(8'h00, 8'h00);
		tx_words.push_back(16'hF0A5);
		send_frame(sys_pkg::CMD_LED);
		check_leds(8'hF0, 8'hA5);
		check_value("led high nibble", 4'hA, led[7:4]);
		end_test();

		start_test("audio_mix");
		for (int round = 0; round < 8; round++) begin
			pick_samples();
			audio_signed = round[0];
			audio_mix = round[1] ? 2'd3 : 2'd0;
			check_audio($sformatf("round %0d", round));
		end
		// Full scale on both sources overflows the sum
		audio_signed = 1'b1;
		audio_mix = 2'd0;
		core_l = 16'h7FFF;
		core_r = 16'h7FFF;
		linux_l = 16'h7FFF;
		linux_r = 16'h7FFF;
		check_audio("full scale");
		check_value("clamp", 16'h7FFF, audio_l);
		tx_words.push_back(16'd3);
		send_frame(sys_pkg::CMD_VOL);
		att_m = 3;
		pick_samples();
		audio_mix = 2'd3;
		check_audio("att 3");
		tx_words.push_back(16'd16);
		send_frame(sys_pkg::CMD_VOL);
		att_m = 16;
		pick_samples();
		check_audio("mute");
		end_test();

		$display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/sys_core_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module sys_core_asserts #(
	parameter int IO_SYNC_STAGES = 2
) (
	input wire logic             i_clk_sys,
	input wire logic             i_resetd,
	input wire logic             i_io_clk,
	input wire logic             i_io_ack,
	input wire sys_pkg::dim_t    i_hmin,
	input wire sys_pkg::dim_t    i_hmax,
	input wire sys_pkg::dim_t    i_vmin,
	input wire sys_pkg::dim_t    i_vmax,
	input wire sys_pkg::aspect_t i_arx,
	input wire sys_pkg::aspect_t i_ary,
	input wire sys_pkg::att_t    i_att,
	input wire sys_pkg::sample_t i_audio_l,
	input wire sys_pkg::sample_t i_audio_r
);

	localparam int ACK_DELAY = IO_SYNC_STAGES + 2;

	logic [3:0]       since_rst;
	logic [4:0]       quiet_cnt;
	logic [3:0]       mute_cnt;
	logic             ack_q;
	sys_pkg::aspect_t arx_q;
	sys_pkg::aspect_t ary_q;

	//////////////////////////////////////////////////
	// Settle counters
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk_sys) begin
		ack_q <= i_io_ack;
		arx_q <= i_arx;
		ary_q <= i_ary;
		if (i_resetd)
			since_rst <= '0;
		else if (since_rst != 4'd15)
			since_rst <= since_rst + 4'd1;
		// Register writes land together with an ack edge
		if (i_resetd || (i_io_ack != ack_q) || (i_arx != arx_q) || (i_ary != ary_q))
			quiet_cnt <= '0;
		else if (quiet_cnt != 5'd31)
			quiet_cnt <= quiet_cnt + 5'd1;
		if (i_resetd || !i_att[4])
			mute_cnt <= '0;
		else if (mute_cnt != 4'd15)
			mute_cnt <= mute_cnt + 4'd1;
	end

	//////////////////////////////////////////////////
	// Properties
	//////////////////////////////////////////////////

	ack_follows_clk: assert property (@(posedge i_clk_sys) disable iff (i_resetd)
		(since_rst >= 4'(ACK_DELAY)) |-> (i_io_ack == $past(i_io_clk, ACK_DELAY)))
		else $error("Host ack does not follow the host clock");

	window_ordered: assert property (@(posedge i_clk_sys) disable iff (i_resetd)
		(quiet_cnt >= 5'd20) |-> ((i_hmin <= i_hmax) && (i_vmin <= i_vmax)))
		else $error("Window minimum above maximum after settling");

	mute_silences: assert property (@(posedge i_clk_sys) disable iff (i_resetd)
		(mute_cnt >= 4'd8) |-> ((i_audio_l == '0) && (i_audio_r == '0)))
		else $error("Audio not silent while muted");

endmodule

bind sys_core_top sys_core_asserts #(
	.IO_SYNC_STAGES(IO_SYNC_STAGES)
) sys_core_asserts_i (
	.i_clk_sys (i_clk_sys),
	.i_resetd  (i_resetd),
	.i_io_clk  (i_io_clk),
	.i_io_ack  (o_io_ack),
	.i_hmin    (o_hmin),
	.i_hmax    (o_hmax),
	.i_vmin    (o_vmin),
	.i_vmax    (o_vmax),
	.i_arx     (i_arx),
	.i_ary     (i_ary),
	.i_att     (att),
	.i_audio_l (o_audio_l),
	.i_audio_r (o_audio_r)
);

`default_nettype wire

// File: logic/sys_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module sys_core_top #(
	parameter int IO_SYNC_STAGES = 2
) (
	input  wire logic                i_clk_sys,
	input  wire logic                i_resetd,

	// Host link
	input  wire logic                i_io_clk,
	input  wire logic                i_io_uio,
	input  wire sys_pkg::host_word_t i_io_din,
	output logic                     o_io_ack,

	// Configuration and LEDs
	output sys_pkg::host_word_t      o_cfg,
	input  wire logic                i_led_user,
	input  wire logic [1:0]          i_led_power,
	input  wire logic [1:0]          i_led_disk,
	output sys_pkg::led_t            o_led,

	// Aspect and window
	input  wire sys_pkg::aspect_t    i_arx,
	input  wire sys_pkg::aspect_t    i_ary,
	output sys_pkg::dim_t            o_hmin,
	output sys_pkg::dim_t            o_hmax,
	output sys_pkg::dim_t            o_vmin,
	output sys_pkg::dim_t            o_vmax,

	// Audio
	input  wire sys_pkg::sample_t    i_core_l,
	input  wire sys_pkg::sample_t    i_core_r,
	input  wire sys_pkg::sample_t    i_linux_l,
	input  wire sys_pkg::sample_t    i_linux_r,
	input  wire logic                i_audio_signed,
	input  wire sys_pkg::mix_t       i_audio_mix,
	output sys_pkg::sample_t         o_audio_l,
	output sys_pkg::sample_t         o_audio_r
);

	sys_pkg::att_t    att;
	sys_pkg::sample_t pre_l;
	sys_pkg::sample_t pre_r;

	video_timing_if timing_bus ();

	//////////////////////////////////////////////////
	// Host side
	//////////////////////////////////////////////////

	host_cfg_regs #(
		.IO_SYNC_STAGES(IO_SYNC_STAGES)
	) host_cfg_regs_i (
		.i_clk_sys   (i_clk_sys),
		.i_resetd    (i_resetd),
		.i_io_clk    (i_io_clk),
		.i_io_uio    (i_io_uio),
		.i_io_din    (i_io_din),
		.o_io_ack    (o_io_ack),
		.o_cfg       (o_cfg),
		.o_att       (att),
		.i_led_user  (i_led_user),
		.i_led_power (i_led_power),
		.i_led_disk  (i_led_disk),
		.o_led       (o_led),
		.timing      (timing_bus.src)
	);

	video_window_calc video_window_calc_i (
		.i_clk_sys (i_clk_sys),
		.i_resetd  (i_resetd),
		.timing    (timing_bus.dst),
		.i_arx     (i_arx),
		.i_ary     (i_ary),
		.o_hmin    (o_hmin),
		.o_hmax    (o_hmax),
		.o_vmin    (o_vmin),
		.o_vmax    (o_vmax)
	);

	//////////////////////////////////////////////////
	// Audio channels
	//////////////////////////////////////////////////

	// Each channel blends in the other channel's half-sum
	audio_channel_mix audio_mix_l_i (
		.i_clk_sys (i_clk_sys),
		.i_resetd  (i_resetd),
		.i_att     (att),
		.i_mix     (i_audio_mix),
		.i_signed  (i_audio_signed),
		.i_core    (i_core_l),
		.i_linux   (i_linux_l),
		.i_pre     (pre_r),
		.o_pre     (pre_l),
		.o_out     (o_audio_l)
	);

	audio_channel_mix audio_mix_r_i (
		.i_clk_sys (i_clk_sys),
		.i_resetd  (i_resetd),
		.i_att     (att),
		.i_mix     (i_audio_mix),
		.i_signed  (i_audio_signed),
		.i_core    (i_core_r),
		.i_linux   (i_linux_r),
		.i_pre     (pre_l),
		.o_pre     (pre_r),
		.o_out     (o_audio_r)
	);

endmodule

`default_nettype wire

// File: logic/audio_channel_mix.sv
`timescale 1ns/10ps
`default_nettype none

module audio_channel_mix (
	input  wire logic             i_clk_sys,
	input  wire logic             i_resetd,
	input  wire sys_pkg::att_t    i_att,
	input  wire sys_pkg::mix_t    i_mix,
	input  wire logic             i_signed,
	input  wire sys_pkg::sample_t i_core,
	input  wire sys_pkg::sample_t i_linux,
	input  wire sys_pkg::sample_t i_pre,
	output sys_pkg::sample_t      o_pre,
	output sys_pkg::sample_t      o_out
);

	sys_pkg::sample_t d1;
	sys_pkg::sample_t d2;
	sys_pkg::sample_t d3;
	sys_pkg::sample_t ca;

	logic signed [16:0] a1;
	logic signed [16:0] a2;
	logic signed [16:0] a3;
	logic signed [16:0] a4;

	//////////////////////////////////////////////////
	// Sample de-glitch
	//////////////////////////////////////////////////

	// A sample is taken only after two delayed copies agree
	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			d1 <= '0;
			d2 <= '0;
			d3 <= '0;
			ca <= '0;
		end else begin
			d1 <= i_core;
			d2 <= d1;
			d3 <= d2;
			if (d2 == d3)
				ca <= d2;
		end
	end

	//////////////////////////////////////////////////
	// Sum, blend and attenuate
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			a1    <= '0;
			a2    <= '0;
			a3    <= '0;
			a4    <= '0;
		end else begin
			// Unsigned samples are halved to fit the signed range
			a1 <= i_signed ? $signed({ca[15], ca}) : $signed({2'b00, ca[15:1]});
			a2 <= a1 + $signed({i_linux[15], i_linux});

			case (i_mix)
				2'd0: a3 <= a2;
				2'd1: a3 <= a2 - (a2 >>> 3) + ($signed(i_pre) >>> 2);
				2'd2: a3 <= a2 - (a2 >>> 2) + ($signed(i_pre) >>> 1);
				default: a3 <= (a2 >>> 1) + $signed(i_pre);
			endcase

			if (i_att[4])
				a4 <= '0;
			else
				a4 <= a3 >>> i_att[3:0];
		end
	end

	// Half-sum for the other channel's blend, in step with its own sum
	assign o_pre = a2[16:1];

	// Saturate to 16 bits when the top two bits disagree
	assign o_out = (a4[16] ^ a4[15]) ? {a4[16], {15{a4[15]}}} : a4[15:0];

endmodule

`default_nettype wire

// File: logic/video_window_calc.sv
`timescale 1ns/10ps
`default_nettype none

module video_window_calc (
	input  wire logic             i_clk_sys,
	input  wire logic             i_resetd,
	video_timing_if.dst           timing,
	input  wire sys_pkg::aspect_t i_arx,
	input  wire sys_pkg::aspect_t i_ary,
	output sys_pkg::dim_t         o_hmin,
	output sys_pkg::dim_t         o_hmax,
	output sys_pkg::dim_t         o_vmin,
	output sys_pkg::dim_t         o_vmax
);

	logic [2:0]    phase;
	logic [19:0]   wcalc;
	logic [19:0]   hcalc;
	sys_pkg::dim_t base_h;
	sys_pkg::dim_t videow;
	sys_pkg::dim_t videoh;
	sys_pkg::dim_t h_off;
	sys_pkg::dim_t v_off;

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd)
			phase <= '0;
		else
			phase <= phase + 3'd1;
	end

	// Vertical override replaces the active height as the reference
	assign base_h = (timing.vset != '0) ? timing.vset : timing.height;

	assign h_off = sys_pkg::dim_t'(timing.width - videow) >> 1;
	assign v_off = sys_pkg::dim_t'(timing.height - videoh) >> 1;

	//////////////////////////////////////////////////
	// Eight phase loop
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk_sys) begin
		case (phase)
			3'd0: begin
				// Zero aspect terms give a zero candidate
				if (i_ary != '0)
					wcalc <= (20'(base_h) * 20'(i_arx)) / 20'(i_ary);
				else
					wcalc <= '0;
				if (i_arx != '0)
					hcalc <= (20'(timing.width) * 20'(i_ary)) / 20'(i_arx);
				else
					hcalc <= '0;
			end
			3'd6: begin
				if ((timing.vset == '0) && (wcalc > 20'(timing.width)))
					videow <= timing.width;
				else
					videow <= wcalc[11:0];

				if (timing.vset != '0)
					videoh <= timing.vset;
				else if (hcalc > 20'(timing.height))
					videoh <= timing.height;
				else
					videoh <= hcalc[11:0];
			end
			3'd7: begin
				// Centre the picture in the active area
				o_hmin <= h_off;
				o_hmax <= h_off + videow - 12'd1;
				o_vmin <= v_off;
				o_vmax <= v_off + videoh - 12'd1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: logic/host_cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none

module host_cfg_regs #(
	parameter int IO_SYNC_STAGES = 2
) (
	input  wire logic                i_clk_sys,
	input  wire logic                i_resetd,
	input  wire logic                i_io_clk,
	input  wire logic                i_io_uio,
	input  wire sys_pkg::host_word_t i_io_din,
	output logic                     o_io_ack,
	output sys_pkg::host_word_t      o_cfg,
	output sys_pkg::att_t            o_att,
	input  wire logic                i_led_user,
	input  wire logic [1:0]          i_led_power,
	input  wire logic [1:0]          i_led_disk,
	output sys_pkg::led_t            o_led,
	video_timing_if.src              timing
);

	logic [IO_SYNC_STAGES-1:0] clk_pipe;
	logic [IO_SYNC_STAGES-1:0] uio_pipe;
	sys_pkg::host_word_t       din_pipe [IO_SYNC_STAGES];

	logic                clk_s;
	logic                uio_s;
	sys_pkg::host_word_t din_s;
	logic                rack;
	logic                strobe_q;

	sys_pkg::dec_state_e state;
	sys_pkg::cmd_t       cmd;
	logic [3:0]          word_cnt;
	sys_pkg::led_t       led_mask;
	sys_pkg::led_t       led_state;
	sys_pkg::led_t       led_auto;
	logic                power_lit;

	//////////////////////////////////////////////////
	// Host input synchroniser
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			clk_pipe <= '0;
			uio_pipe <= '0;
		end else begin
			clk_pipe[0] <= i_io_clk;
			uio_pipe[0] <= i_io_uio;
			for (int i = 1; i < IO_SYNC_STAGES; i++) begin
				clk_pipe[i] <= clk_pipe[i-1];
				uio_pipe[i] <= uio_pipe[i-1];
			end
		end
	end

	// Data word is held by the host until ack, so no reset needed here
	always_ff @(posedge i_clk_sys) begin
		din_pipe[0] <= i_io_din;
		for (int i = 1; i < IO_SYNC_STAGES; i++) begin
			din_pipe[i] <= din_pipe[i-1];
		end
	end

	assign clk_s = clk_pipe[IO_SYNC_STAGES-1];
	assign uio_s = uio_pipe[IO_SYNC_STAGES-1];
	assign din_s = din_pipe[IO_SYNC_STAGES-1];

	// Strobe on the rising edge of the synced clock, ack two cycles behind it
	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			rack     <= 1'b0;
			o_io_ack <= 1'b0;
			strobe_q <= 1'b0;
		end else begin
			rack     <= clk_s;
			o_io_ack <= rack;
			strobe_q <= clk_s & ~rack;
		end
	end

	//////////////////////////////////////////////////
	// Command decoder and register file
	//////////////////////////////////////////////////

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			state         <= sys_pkg::DEC_IDLE;
			cmd           <= '0;
			word_cnt      <= '0;
			o_cfg         <= '0;
			o_att         <= '0;
			led_mask      <= '0;
			led_state     <= '0;
			timing.width  <= sys_pkg::DEF_WIDTH;
			timing.hfp    <= sys_pkg::DEF_HFP;
			timing.hs     <= sys_pkg::DEF_HS;
			timing.hbp    <= sys_pkg::DEF_HBP;
			timing.height <= sys_pkg::DEF_HEIGHT;
			timing.vfp    <= sys_pkg::DEF_VFP;
			timing.vs     <= sys_pkg::DEF_VS;
			timing.vbp    <= sys_pkg::DEF_VBP;
			timing.vset   <= '0;
		end else if (!uio_s) begin
			state <= sys_pkg::DEC_IDLE;
		end else if (strobe_q) begin
			case (state)
				sys_pkg::DEC_IDLE: begin
					state    <= sys_pkg::DEC_DATA;
					cmd      <= din_s[7:0];
					word_cnt <= '0;
				end
				sys_pkg::DEC_DATA: begin
					case (cmd)
						sys_pkg::CMD_CFG: o_cfg <= din_s;
						sys_pkg::CMD_TIMING: begin
							// Counter parks at 8 so trailing words fall through
							if (word_cnt < 4'd8)
								word_cnt <= word_cnt + 4'd1;
							case (word_cnt)
								4'd0: timing.width  <= din_s[11:0];
								4'd1: timing.hfp    <= din_s[11:0];
								4'd2: timing.hs     <= din_s[11:0];
								4'd3: timing.hbp    <= din_s[11:0];
								4'd4: timing.height <= din_s[11:0];
								4'd5: timing.vfp    <= din_s[11:0];
								4'd6: timing.vs     <= din_s[11:0];
								4'd7: timing.vbp    <= din_s[11:0];
								default: ;
							endcase
						end
						sys_pkg::CMD_LED: {led_mask, led_state} <= din_s;
						sys_pkg::CMD_VOL: o_att <= din_s[4:0];
						sys_pkg::CMD_VSET: timing.vset <= din_s[11:0];
						default: ;
					endcase
				end
				default: state <= sys_pkg::DEC_IDLE;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Main board LEDs
	//////////////////////////////////////////////////

	// Power LED stays lit unless the core takes control of it
	assign power_lit = i_led_power[1] ? i_led_power[0] : 1'b1;

	// Disk override bit only mattered with the dropped activity term
	assign led_auto = {3'b000, power_lit, 1'b0, i_led_disk[0], 1'b0, i_led_user};

	assign o_led = (led_mask & led_state) | (~led_mask & led_auto);

endmodule

`default_nettype wire

// File: logic/video_timing_if.sv
`timescale 1ns/10ps
`default_nettype none

interface video_timing_if;

	// Horizontal set
	sys_pkg::dim_t width;
	sys_pkg::dim_t hfp;
	sys_pkg::dim_t hs;
	sys_pkg::dim_t hbp;

	// Vertical set
	sys_pkg::dim_t height;
	sys_pkg::dim_t vfp;
	sys_pkg::dim_t vs;
	sys_pkg::dim_t vbp;

	// Zero means no vertical override
	sys_pkg::dim_t vset;

	modport src (
		output width, hfp, hs, hbp,
		output height, vfp, vs, vbp,
		output vset
	);

	modport dst (
		input width, hfp, hs, hbp,
		input height, vfp, vs, vbp,
		input vset
	);

endinterface

`default_nettype wire

// File: logic/sys_pkg.sv
`default_nettype none

package sys_pkg;

	//////////////////////////////////////////////////
	// Widths with a meaning
	//////////////////////////////////////////////////

	typedef logic [15:0] host_word_t;
	typedef logic [7:0]  cmd_t;
	typedef logic [11:0] dim_t;
	typedef logic [7:0]  aspect_t;
	typedef logic [15:0] sample_t;
	// Bit 4 mutes, bits 3..0 give the right shift
	typedef logic [4:0]  att_t;
	typedef logic [1:0]  mix_t;
	typedef logic [7:0]  led_t;

	// Host command codes
	localparam cmd_t CMD_CFG    = 8'h01;
	localparam cmd_t CMD_TIMING = 8'h20;
	localparam cmd_t CMD_LED    = 8'h25;
	localparam cmd_t CMD_VOL    = 8'h26;
	localparam cmd_t CMD_VSET   = 8'h27;

	// 1920x1080 timing after reset
	localparam dim_t DEF_WIDTH  = 12'd1920;
	localparam dim_t DEF_HFP    = 12'd88;
	localparam dim_t DEF_HS     = 12'd48;
	localparam dim_t DEF_HBP    = 12'd148;
	localparam dim_t DEF_HEIGHT = 12'd1080;
	localparam dim_t DEF_VFP    = 12'd4;
	localparam dim_t DEF_VS     = 12'd5;
	localparam dim_t DEF_VBP    = 12'd36;

	//////////////////////////////////////////////////
	// Decoder FSM
	//////////////////////////////////////////////////

	typedef enum logic {
		DEC_IDLE,
		DEC_DATA
	} dec_state_e;

endpackage

`default_nettype wire
